/* Makefile */
TOP = tb_uart_echo

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -Mdir obj_dir -f uart_echo.f

run: build
	./obj_dir/V$(TOP) | tee run.log
	grep -qF "Simulation finished: PASS" run.log

lint:
	verilator --lint-only --timing --assert -Wall --timescale 1ns/1ps \
		--top-module $(TOP) -f uart_echo.f

clean:
	rm -rf obj_dir run.log

/* rtl/echo_ctrl.sv */
// APB master FSM: configures the UART, polls status, reads and echoes bytes, drives the LED
module echo_ctrl (
    input  logic                    i_pll_clk,
    input  logic                    i_rst_n,
    output uart_echo_pkg::apb_req_t o_req,
    input  uart_echo_pkg::apb_rsp_t i_rsp,
    input  uart_echo_pkg::irq_t     i_irq,
    output logic                    o_led
);
    import uart_echo_pkg::*;

    enum logic [3:0] {
        ST_BAUD_L,
        ST_BAUD_H,
        ST_INT_EN,
        ST_POLL,
        ST_CHECK,
        ST_RD_DATA,
        ST_GAP,
        ST_WR_DATA,
        ST_CLR_INT,
        ST_XFER
    } state, ret_state;                 // ret_state resumes after a transfer

    uart_word_u  rd_word;
    logic [31:0] gap_cnt;

    function automatic apb_req_t apb_setup(input logic       wr,
                                           input logic [7:0] addr,
                                           input logic [7:0] wdata);
        return '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
    endfunction

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst_n) begin
            state     <= ST_BAUD_L;
            ret_state <= ST_BAUD_L;
            o_req     <= '0;
            gap_cnt   <= '0;
            o_led     <= 1'b0;
        end else begin
            o_led <= |i_irq;
            case (state)
                ST_BAUD_L: begin
                    o_req     <= apb_setup(1'b1, ADDR_BAUD_L, BAUD_DIV[7:0]);
                    ret_state <= ST_BAUD_H;
                    state     <= ST_XFER;
                end
                ST_BAUD_H: begin
                    o_req     <= apb_setup(1'b1, ADDR_BAUD_H, BAUD_DIV[15:8]);
                    ret_state <= ST_INT_EN;
                    state     <= ST_XFER;
                end
                ST_INT_EN: begin
                    o_req     <= apb_setup(1'b1, ADDR_INT_EN, 8'h03);  // rx and tx
                    ret_state <= ST_POLL;
                    state     <= ST_XFER;
                end
                ST_POLL: begin
                    o_req     <= apb_setup(1'b0, ADDR_STATUS, 8'h00);
                    ret_state <= ST_CHECK;
                    state     <= ST_XFER;
                end
                ST_CHECK: begin
                    if (rd_word.status.rx_avail && !rd_word.status.tx_full) begin
                        state <= ST_RD_DATA;
                    end else begin
                        state <= ST_POLL;
                    end
                end
                ST_RD_DATA: begin
                    o_req     <= apb_setup(1'b0, ADDR_DATA, 8'h00);
                    gap_cnt   <= ECHO_GAP;
                    ret_state <= ST_GAP;
                    state     <= ST_XFER;
                end
                ST_GAP: begin
                    if (gap_cnt == '0) begin
                        state <= ST_WR_DATA;
                    end else begin
                        gap_cnt <= gap_cnt - 1'b1;
                    end
                end
                ST_WR_DATA: begin
                    o_req     <= apb_setup(1'b1, ADDR_DATA, rd_word.data);
                    ret_state <= ST_CLR_INT;
                    state     <= ST_XFER;
                end
                ST_CLR_INT: begin
                    o_req     <= apb_setup(1'b1, ADDR_INT_PEND, 8'h03);  // w1c both
                    ret_state <= ST_POLL;
                    state     <= ST_XFER;
                end
                ST_XFER: begin
                    if (!o_req.penable) begin
                        o_req.penable <= 1'b1;             // access phase
                    end else if (i_rsp.pready) begin
                        o_req.psel    <= 1'b0;
                        o_req.penable <= 1'b0;
                        state         <= ret_state;
                    end
                end
                default: state <= ST_BAUD_L;
            endcase
        end
    end

    // last read word, status or data byte
    always_ff @(posedge i_pll_clk) begin
        if (state == ST_XFER && o_req.penable && i_rsp.pready && !o_req.pwrite) begin
            rd_word <= i_rsp.prdata;
        end
    end

    a_apb_stable: assert property (@(posedge i_pll_clk) disable iff (!i_rst_n)
        o_req.psel && o_req.penable |->
            $stable(o_req.paddr) && $stable(o_req.pwdata) && $stable(o_req.pwrite));

endmodule

/* rtl/sync_fifo.sv */
// single-clock byte FIFO: circular buffer, read and write pointers, count, full/empty flags
module sync_fifo (
    input  logic       i_pll_clk,
    input  logic       i_rst_n,
    input  logic       i_push,
    input  logic       i_pop,
    input  logic [7:0] i_data,
    output logic [7:0] o_data,
    output logic       o_full,
    output logic       o_empty
);
    import uart_echo_pkg::*;

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;

    assign o_data  = mem[rd_ptr];       // head word visible before the pop
    assign o_full  = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign o_empty = (count == '0);

    always_ff @(posedge i_pll_clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({i_push, i_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
        end
    end

    a_no_push_full: assert property (@(posedge i_pll_clk) disable iff (!i_rst_n)
        !(i_push && o_full));
    a_no_pop_empty: assert property (@(posedge i_pll_clk) disable iff (!i_rst_n)
        !(i_pop && o_empty));

endmodule

/* rtl/uart_echo_pkg.sv */
// register map, timing constants, APB request/response structs, read-word union, irq flags
package uart_echo_pkg;

    localparam logic [7:0] ADDR_BAUD_L   = 8'h00;
    localparam logic [7:0] ADDR_BAUD_H   = 8'h01;
    localparam logic [7:0] ADDR_INT_EN   = 8'h02;
    localparam logic [7:0] ADDR_INT_PEND = 8'h03;   // write 1 to clear
    localparam logic [7:0] ADDR_STATUS   = 8'h04;
    localparam logic [7:0] ADDR_DATA     = 8'h05;   // read pops rx, write pushes tx

    localparam logic [15:0] BAUD_DIV   = 16'd16;    // clocks per bit, sim speed
    localparam logic [31:0] ECHO_GAP   = 32'd64;    // hold time before the echo write
    localparam int          FIFO_DEPTH = 8;
    localparam int          FIFO_AW    = $clog2(FIFO_DEPTH);

    typedef struct packed {
        logic       psel;
        logic       penable;
        logic       pwrite;
        logic [7:0] paddr;
        logic [7:0] pwdata;
    } apb_req_t;

    // bit 0 is rx_avail, bit 1 is tx_full
    typedef struct packed {
        logic [3:0] rsvd;
        logic       frame_err;
        logic       rx_overrun;
        logic       tx_full;
        logic       rx_avail;
    } uart_status_t;

    typedef union packed {
        uart_status_t status;   // view of ADDR_STATUS
        logic [7:0]   data;     // view of every other register
    } uart_word_u;

    typedef struct packed {
        logic       pready;
        logic       pslverr;
        uart_word_u prdata;
    } apb_rsp_t;

    typedef struct packed {
        logic tx;
        logic rx;               // lsb, matches bit 0 of INT_EN / INT_PEND
    } irq_t;

endpackage

/* rtl/uart_echo_top.sv */
// top level: APB controller, UART register block and the serial pins
module uart_echo_top (
    input  logic i_pll_clk,
    input  logic i_rst_n,
    input  logic i_rx,
    output logic o_tx,
    output logic o_led
);
    import uart_echo_pkg::*;

    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    irq_t     irq;

    echo_ctrl u_echo_ctrl (
        .i_pll_clk(i_pll_clk),
        .i_rst_n  (i_rst_n),
        .o_req    (apb_req),
        .i_rsp    (apb_rsp),
        .i_irq    (irq),
        .o_led    (o_led)
    );

    uart_regs u_uart_regs (
        .i_pll_clk(i_pll_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (apb_req),
        .o_rsp    (apb_rsp),
        .o_irq    (irq),
        .i_rx     (i_rx),
        .o_tx     (o_tx)
    );

endmodule

/* rtl/uart_regs.sv */
// APB register block with baud divider, irq enable and pending bits, sticky status, rx and tx FIFOs
module uart_regs (
    input  logic                    i_pll_clk,
    input  logic                    i_rst_n,
    input  uart_echo_pkg::apb_req_t i_req,
    output uart_echo_pkg::apb_rsp_t o_rsp,
    output uart_echo_pkg::irq_t     o_irq,
    input  logic                    i_rx,
    output logic                    o_tx
);
    import uart_echo_pkg::*;

    logic [15:0] baud_div;
    irq_t        int_en;
    irq_t        int_pend;
    logic        rx_overrun;
    logic        frame_err;
    logic        rx_valid;
    logic        rx_ferr;
    logic [7:0]  rx_byte;
    logic        rx_push;
    logic        rx_pop;
    logic        rx_full;
    logic        rx_empty;
    logic [7:0]  rx_data;
    logic        tx_push;
    logic        tx_pop;
    logic        tx_full;
    logic        tx_empty;
    logic [7:0]  tx_data;
    logic [19:0] tx_left;                                  // cycles left in the frame on o_tx
    logic        access;
    logic        wr;
    logic        rd;
    logic        addr_ok;
    uart_word_u  rd_word;

    assign access  = i_req.psel && i_req.penable;
    assign wr      = access && i_req.pwrite;
    assign rd      = access && !i_req.pwrite;
    assign addr_ok = i_req.paddr inside {ADDR_BAUD_L, ADDR_BAUD_H, ADDR_INT_EN,
                                         ADDR_INT_PEND, ADDR_STATUS, ADDR_DATA};
    assign rx_push = rx_valid && !rx_full;                 // full fifo drops the byte
    assign rx_pop  = rd && (i_req.paddr == ADDR_DATA) && !rx_empty;
    assign tx_push = wr && (i_req.paddr == ADDR_DATA) && !tx_full;
    assign o_irq   = int_pend & int_en;

    assign o_rsp.pready  = access;                         // zero wait states
    assign o_rsp.pslverr = access && (!addr_ok ||
                           (i_req.pwrite && i_req.paddr == ADDR_DATA && tx_full));
    assign o_rsp.prdata  = rd_word;

    always_comb begin
        rd_word = '0;
        case (i_req.paddr)
            ADDR_BAUD_L:   rd_word.data = baud_div[7:0];
            ADDR_BAUD_H:   rd_word.data = baud_div[15:8];
            ADDR_INT_EN:   rd_word.data = {6'd0, int_en};
            ADDR_INT_PEND: rd_word.data = {6'd0, int_pend};
            ADDR_STATUS: begin
                rd_word.status.rx_avail   = !rx_empty;
                rd_word.status.tx_full    = tx_full;
                rd_word.status.rx_overrun = rx_overrun;
                rd_word.status.frame_err  = frame_err;
            end
            ADDR_DATA:     rd_word.data = rx_empty ? 8'h00 : rx_data;
            default:       rd_word = '0;            // unknown address reads zero
        endcase
    end

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst_n) begin
            baud_div   <= '0;
            int_en     <= '0;
            int_pend   <= '0;
            rx_overrun <= 1'b0;
            frame_err  <= 1'b0;
            tx_left    <= '0;
        end else begin
            if (wr) begin
                case (i_req.paddr)
                    ADDR_BAUD_L:   baud_div[7:0]  <= i_req.pwdata;
                    ADDR_BAUD_H:   baud_div[15:8] <= i_req.pwdata;
                    ADDR_INT_EN:   int_en         <= i_req.pwdata[1:0];
                    ADDR_INT_PEND: int_pend       <= int_pend & ~i_req.pwdata[1:0];
                    default:       ;
                endcase
            end
            if (rd && i_req.paddr == ADDR_STATUS) begin    // sticky bits clear on read
                rx_overrun <= 1'b0;
                frame_err  <= 1'b0;
            end
            if (tx_pop) begin
                tx_left <= 20'(baud_div) * 20'd10;         // ten bit-times per frame
            end else if (tx_left != '0) begin
                tx_left <= tx_left - 1'b1;
            end
            // new events win over a same-cycle clear
            if (rx_push)             int_pend.rx <= 1'b1;
            if (tx_left == 20'd1)    int_pend.tx <= 1'b1;  // stop bit done
            if (rx_valid && rx_full) rx_overrun  <= 1'b1;
            if (rx_ferr)             frame_err   <= 1'b1;
        end
    end

    uart_rx u_uart_rx (
        .i_pll_clk  (i_pll_clk),
        .i_rst_n    (i_rst_n),
        .i_rx       (i_rx),
        .i_baud_div (baud_div),
        .o_valid    (rx_valid),
        .o_frame_err(rx_ferr),
        .o_byte     (rx_byte)
    );

    sync_fifo u_rx_fifo (
        .i_pll_clk(i_pll_clk),
        .i_rst_n  (i_rst_n),
        .i_push   (rx_push),
        .i_pop    (rx_pop),
        .i_data   (rx_byte),
        .o_data   (rx_data),
        .o_full   (rx_full),
        .o_empty  (rx_empty)
    );

    sync_fifo u_tx_fifo (
        .i_pll_clk(i_pll_clk),
        .i_rst_n  (i_rst_n),
        .i_push   (tx_push),
        .i_pop    (tx_pop),
        .i_data   (i_req.pwdata),
        .o_data   (tx_data),
        .o_full   (tx_full),
        .o_empty  (tx_empty)
    );

    uart_tx u_uart_tx (
        .i_pll_clk (i_pll_clk),
        .i_rst_n   (i_rst_n),
        .i_baud_div(baud_div),
        .i_empty   (tx_empty),
        .i_byte    (tx_data),
        .o_pop     (tx_pop),
        .o_tx      (o_tx)
    );

    // ready only in an access phase that follows a setup phase
    a_pready_access: assert property (@(posedge i_pll_clk) disable iff (!i_rst_n)
        o_rsp.pready |-> i_req.psel && i_req.penable && $past(i_req.psel && !i_req.penable));

endmodule

/* rtl/uart_rx.sv */
// serial receiver with two-flop synchronizer, start detect, mid-bit sampling and stop-bit check
module uart_rx (
    input  logic        i_pll_clk,
    input  logic        i_rst_n,
    input  logic        i_rx,
    input  logic [15:0] i_baud_div,
    output logic        o_valid,
    output logic        o_frame_err,
    output logic [7:0]  o_byte
);
    enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} state;

    logic        rx_meta;
    logic        rx_sync;
    logic        rx_prev;
    logic [15:0] cnt;
    logic [2:0]  bit_idx;
    logic [7:0]  shreg;

    assign o_byte = shreg;

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst_n) begin
            rx_meta <= 1'b1;                       // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst_n) begin
            state       <= RX_IDLE;
            cnt         <= '0;
            bit_idx     <= '0;
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
        end else begin
            o_valid     <= 1'b0;
            o_frame_err <= 1'b0;
            case (state)
                RX_IDLE: begin
                    if (rx_prev && !rx_sync) begin    // falling edge of start bit
                        cnt   <= {1'b0, i_baud_div[15:1]};
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else if (!rx_sync) begin      // still low at mid start
                        cnt     <= i_baud_div - 1'b1;
                        bit_idx <= '0;
                        state   <= RX_DATA;
                    end else begin
                        state <= RX_IDLE;             // only a glitch
                    end
                end
                RX_DATA: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        cnt     <= i_baud_div - 1'b1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end
                end
                RX_STOP: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        o_valid     <= rx_sync;       // mid stop bit
                        o_frame_err <= !rx_sync;
                        state       <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge i_pll_clk) begin
        if (state == RX_DATA && cnt == '0) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
    end

    // one result per frame, stop level still steady one cycle after the sample
    a_stop_result: assert property (@(posedge i_pll_clk) disable iff (!i_rst_n)
        (o_valid || o_frame_err) |-> (o_valid != o_frame_err) && (rx_sync == o_valid));

endmodule

/* rtl/uart_tx.sv */
// serial transmitter: pops a byte when idle, sends start, 8 data bits lsb first, stop
module uart_tx (
    input  logic        i_pll_clk,
    input  logic        i_rst_n,
    input  logic [15:0] i_baud_div,
    input  logic        i_empty,
    input  logic [7:0]  i_byte,
    output logic        o_pop,
    output logic        o_tx
);
    enum logic {TX_IDLE, TX_SHIFT} state;

    logic [9:0]  shreg;                 // {stop, data, start}
    logic [15:0] cnt;
    logic [3:0]  bit_idx;

    assign o_pop = (state == TX_IDLE) && !i_empty;
    assign o_tx  = shreg[0];            // flop output, ones when idle

    always_ff @(posedge i_pll_clk) begin
        if (!i_rst_n) begin
            state   <= TX_IDLE;
            shreg   <= '1;
            cnt     <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                TX_IDLE: begin
                    if (o_pop) begin
                        shreg   <= {1'b1, i_byte, 1'b0};
                        cnt     <= i_baud_div - 1'b1;
                        bit_idx <= '0;
                        state   <= TX_SHIFT;
                    end
                end
                TX_SHIFT: begin
                    if (cnt != '0) begin
                        cnt <= cnt - 1'b1;
                    end else begin
                        shreg   <= {1'b1, shreg[9:1]};    // refill with idle level
                        cnt     <= i_baud_div - 1'b1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 4'd9) begin         // stop bit done
                            state <= TX_IDLE;
                        end
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

endmodule

/* sim/tb_uart_echo.sv */
// testbench top: clock, reset, seeded random bytes, echo tests, timeout and summary
module tb_uart_echo;
    timeunit 1ns;
    timeprecision 1ps;
    import uart_echo_pkg::*;

    localparam int N_SINGLE    = 20;
    localparam int N_BURST     = 6;
    localparam int N_BYTES     = N_SINGLE + N_BURST + 3;
    localparam int N_ECHOES    = N_SINGLE + N_BURST + 2;  // bad frame is dropped
    localparam int FRAME_CYC   = 10 * int'(BAUD_DIV);
    localparam int TIMEOUT_CYC = N_BYTES * FRAME_CYC * 3 + int'(ECHO_GAP) * N_BYTES;

    logic pll_clk = 1'b0;
    logic rst_n   = 1'b0;
    logic rx;
    logic tx;
    logic led;
    int   outstanding;
    int   echo_cnt;
    int   model_errs;
    int   led_miss;
    int   tb_errs = 0;
    int   cycle   = 0;

    always #4 pll_clk = ~pll_clk;

    uart_echo_top u_uart_echo_top (
        .i_pll_clk(pll_clk),
        .i_rst_n  (rst_n),
        .i_rx     (rx),
        .o_tx     (tx),
        .o_led    (led)
    );

    tb_uart_model u_model (
        .i_pll_clk    (pll_clk),
        .i_tx         (tx),
        .i_led        (led),
        .o_rx         (rx),
        .o_outstanding(outstanding),
        .o_echo_cnt   (echo_cnt),
        .o_err_cnt    (model_errs),
        .o_led_miss   (led_miss)
    );

    always @(posedge pll_clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles: the echo never arrived, %0d bytes still owed",
                     cycle, outstanding);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic int total_errors();
        return tb_errs + model_errs;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge pll_clk);
    endtask

    // o_tx idle high and o_led low on every cycle
    task automatic check_idle_lines(input int n);
        repeat (n) begin
            @(negedge pll_clk);
            if (tx !== 1'b1) begin
                $display("MISMATCH time=%0t signal=o_tx expected=1 actual=%b", $time, tx);
                tb_errs++;
            end
            if (led !== 1'b0) begin
                $display("MISMATCH time=%0t signal=o_led expected=0 actual=%b", $time, led);
                tb_errs++;
            end
        end
    endtask

    task automatic wait_drain();
        while (outstanding != 0) begin
            @(negedge pll_clk);
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    initial begin
        int         errs_start;
        logic [7:0] b;
        void'($urandom(32'hfa4f1c59));

        errs_start = total_errors();
        check_idle_lines(16);                  // reset held for 16 cycles
        rst_n = 1'b1;
        check_idle_lines(40);                  // config runs, no byte yet
        report_test(1, "reset_state", total_errors() - errs_start);

        errs_start = total_errors();
        for (int i = 0; i < N_SINGLE; i++) begin
            b = 8'($urandom());
            u_model.send_byte(b, 1'b1);
            idle_cycles(FRAME_CYC);            // two frame times per byte
        end
        wait_drain();
        report_test(2, "single_echo", total_errors() - errs_start);

        errs_start = total_errors();
        for (int i = 0; i < N_BURST; i++) begin
            b = 8'($urandom());
            u_model.send_byte(b, 1'b1);        // back to back
        end
        wait_drain();
        report_test(3, "burst_buffering", total_errors() - errs_start);

        errs_start = total_errors();
        b = 8'($urandom());
        u_model.send_byte(b, 1'b1);
        b = 8'($urandom());
        u_model.send_byte(b, 1'b0);            // stop bit low
        idle_cycles(FRAME_CYC);
        b = 8'($urandom());
        u_model.send_byte(b, 1'b1);
        wait_drain();
        idle_cycles(2 * FRAME_CYC);            // room for a stray echo
        report_test(4, "framing_error", total_errors() - errs_start);

        report_test(5, "interrupt_led", led_miss);

        if (echo_cnt != N_ECHOES) begin
            $display("%0d echoed bytes were expected but %0d came back", N_ECHOES, echo_cnt);
            tb_errs++;
        end
        $display("summary: 5 tests, %0d bytes echoed, %0d errors", echo_cnt, total_errors());
        if (total_errors() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* sim/tb_uart_model.sv */
// serial line driver for i_rx, o_tx decoder, expected-byte queue and LED window check
module tb_uart_model (
    input  logic i_pll_clk,
    input  logic i_tx,
    input  logic i_led,
    output logic o_rx,
    output int   o_outstanding,
    output int   o_echo_cnt,
    output int   o_err_cnt,
    output int   o_led_miss
);
    timeunit 1ns;
    timeprecision 1ps;
    import uart_echo_pkg::*;

    typedef struct packed {
        logic [7:0]  data;
        logic [31:0] end_cyc;                  // cycle the input frame ends
    } exp_t;

    exp_t        exp_q[$];
    logic [31:0] cyc     = '0;
    logic [31:0] led_cyc = '0;                 // last cycle o_led was high

    initial o_rx = 1'b1;                       // line idles high

    always @(negedge i_pll_clk) begin
        cyc           <= cyc + 32'd1;
        o_outstanding <= exp_q.size();
        if (i_led === 1'b1) begin
            led_cyc <= cyc;
        end
    end

    // start bit then 8 data bits lsb first then stop bit, BAUD_DIV cycles per bit
    task automatic send_byte(input logic [7:0] data, input logic good_stop);
        logic [9:0] frame;
        exp_t       entry;
        frame = {good_stop, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge i_pll_clk);
            o_rx = frame[i];
            if (i == 9 && good_stop) begin     // only good frames come back
                entry.data    = data;
                entry.end_cyc = cyc + 32'(BAUD_DIV);
                exp_q.push_back(entry);
            end
            repeat (BAUD_DIV - 1) @(negedge i_pll_clk);
        end
        if (!good_stop) begin
            @(negedge i_pll_clk);
            o_rx = 1'b1;                       // release line after low stop bit
        end
    endtask

    initial begin : decode
        logic [7:0] data;
        logic       stop;
        exp_t       head;
        o_echo_cnt = 0;
        o_err_cnt  = 0;
        o_led_miss = 0;
        forever begin
            @(negedge i_pll_clk);
            if (i_tx === 1'b0) begin           // start edge
                repeat (BAUD_DIV / 2) @(negedge i_pll_clk);
                if (i_tx !== 1'b0) begin
                    $display("%0t: start bit on o_tx ended before mid-bit", $time);
                    o_err_cnt++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (BAUD_DIV) @(negedge i_pll_clk);
                    data[i] = i_tx;
                end
                repeat (BAUD_DIV) @(negedge i_pll_clk);
                stop = i_tx;
                if (stop !== 1'b1) begin
                    $display("MISMATCH time=%0t signal=o_tx_stop expected=1 actual=%b",
                             $time, stop);
                    o_err_cnt++;
                end
                o_echo_cnt++;                  // every frame seen on o_tx
                if (exp_q.size() == 0) begin
                    $display("%0t: byte 8'h%02h appeared on o_tx but none was expected",
                             $time, data);
                    o_err_cnt++;
                end else begin
                    head = exp_q.pop_front();
                    if (data !== head.data) begin
                        $display("MISMATCH time=%0t signal=o_tx expected=8'h%02h actual=8'h%02h",
                                 $time, head.data, data);
                        o_err_cnt++;
                    end
                    if (led_cyc < head.end_cyc) begin
                        $display("%0t: o_led stayed low for the whole echo of byte 8'h%02h",
                                 $time, head.data);
                        o_err_cnt++;
                        o_led_miss++;
                    end
                end
            end
        end
    end

endmodule

/* uart_echo.f */
rtl/uart_echo_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/sync_fifo.sv
rtl/uart_regs.sv
rtl/echo_ctrl.sv
rtl/uart_echo_top.sv
sim/tb_uart_model.sv
sim/tb_uart_echo.sv
